/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/fetch_sva.sv */
`default_nettype none

module fetch_sva (
    input wire       clk,
    input wire       arst_n,
    input wire       redirect,
    input wire       drop_pending,
    input wire       load_valid,
    input wire       fetch_gnt,
    input wire [3:0] deny_cnt
);

    int fail_cnt = 0; // summed into the closing report

    drop_clear_in_reset: assert property (@(posedge clk) !arst_n |-> !drop_pending)
        else begin
            fail_cnt++;
            $error("pending drop flag set while in reset");
        end

    drop_clear_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !drop_pending)
        else begin
            fail_cnt++;
            $error("pending drop flag set right after reset");
        end

    // flag may only rise on the edge that saw a redirect
    drop_needs_redirect: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(drop_pending) |-> $past(redirect)
    ) else begin
        fail_cnt++;
        $error("pending drop flag set without a redirect");
    end

    load_wins: assert property (@(posedge clk) disable iff (!arst_n) load_valid |-> !fetch_gnt)
        else begin
            fail_cnt++;
            $error("fetch granted while a load was pending");
        end

    no_starvation: assert property (@(posedge clk) disable iff (!arst_n) deny_cnt <= 4'd8)
        else begin
            fail_cnt++;
            $error("fetch denied more than 8 cycles in a row");
        end

endmodule

// if_id has no arbiter signals, tied off here
bind if_id fetch_sva sva0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .redirect     (redirect),
    .drop_pending (drop_pending),
    .load_valid   (1'b0),
    .fetch_gnt    (1'b0),
    .deny_cnt     (4'd0)
);

bind mem_arbiter fetch_sva sva0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .redirect     (1'b0),
    .drop_pending (1'b0),
    .load_valid   (load_valid),
    .fetch_gnt    (fetch_gnt),
    .deny_cnt     (deny_cnt)
);

`default_nettype wire

/* verification/fetch_tb.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;     // after the rising edge
    localparam int DEPTH        = `FETCH_MEM_DEPTH;
    localparam int AW           = $clog2(`FETCH_MEM_DEPTH);
    localparam int RESET_CYCLES = 5;
    localparam int SEQ_CYCLES   = 40;
    localparam int STALL_CYCLES = 80;
    localparam int REDIR_CYCLES = 60;
    localparam int LOAD_CYCLES  = 80;
    localparam int DRAIN_CYCLES = 10;
    localparam int TOTAL_CYCLES = RESET_CYCLES + DEPTH + SEQ_CYCLES + 3 + STALL_CYCLES
                                + REDIR_CYCLES + LOAD_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    logic                   clk;
    logic                   arst_n;
    logic                   fetch_en;
    logic                   stall;
    logic                   redirect;
    logic [`FETCH_XLEN-1:0] redirect_pc;
    logic                   load_we;
    logic [`FETCH_XLEN-1:0] load_addr;
    logic [`FETCH_XLEN-1:0] load_data;
    if_id_t                 id;

    logic [`FETCH_XLEN-1:0] shadow [DEPTH];  // expected memory contents
    logic [`FETCH_XLEN-1:0] exp_pc;          // next valid pc decode should see
    logic                   skip;            // id repeats or is flushed next cycle
    logic [31:0]            rand_state = 32'h2ca7;
    int                     errors = 0;
    int                     sva_errors;
    int                     checked = 0;
    string                  phase = "reset";

    fetch_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_en    (fetch_en),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .id          (id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic report_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("MISMATCH [%s] %s: expected %h, actual %h", phase, what, exp, act);
    endtask

    task automatic report_failure(string what);
        errors++;
        $display("ERROR [%s] %s", phase, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // flush lands on the edge that samples the redirect
    flush_after_redirect: assert property (
        @(posedge clk) disable iff (!arst_n) redirect |=> !id.valid
    ) else report_failure("id.valid still high on the edge after a redirect");

    hold_while_stalled: assert property (
        @(posedge clk) disable iff (!arst_n) (stall && !redirect) |=> $stable(id)
    ) else report_failure("id changed while the front end was stalled");

    // order and content, sampled mid cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!id.valid)
                else report_mismatch("reset id.valid", 32'd0, {31'd0, id.valid});
            exp_pc = `FETCH_RESET_PC;
            skip   = 1'b0;
        end else begin
            if (!skip && id.valid) begin
                assert (id.pc == exp_pc)
                    else report_mismatch("id.pc order", exp_pc, id.pc);
                assert (id.inst == shadow[id.pc[AW+1:2]])
                    else report_mismatch("id.inst content", shadow[id.pc[AW+1:2]], id.inst);
                exp_pc = exp_pc + 32'd4; // next pc in program order
                checked++;
            end
            skip = stall | redirect;
            if (redirect) begin
                exp_pc = redirect_pc;
            end
        end
    end

    initial begin
        #WATCHDOG_TIME;
        $display("timeout: stimulus still running after %0d time units", WATCHDOG_TIME);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0]   r;
        logic [AW-1:0] idx;
        int            burst;

        arst_n      = 1'b0;
        fetch_en    = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        // program image through the load port, fetch idle
        phase = "preload";
        for (int i = 0; i < DEPTH; i++) begin
            r         = next_rand();
            idx       = AW'(i);
            load_we   = 1'b1;
            load_addr = `FETCH_XLEN'(idx);
            load_data = r;
            shadow[idx] = r;
            next_cycle();
        end
        load_we = 1'b0;

        phase    = "sequential";
        fetch_en = 1'b1;
        repeat (SEQ_CYCLES) next_cycle();

        phase = "stall";
        stall = 1'b1;
        next_cycle();
        redirect    = 1'b1;  // redirect inside a stall
        redirect_pc = 32'h0000_0040;
        next_cycle();
        redirect = 1'b0;
        next_cycle();
        stall = 1'b0;
        for (int c = 0; c < STALL_CYCLES; c++) begin
            r = next_rand();
            if (r[5:4] == 2'b00) begin
                stall = ~stall;
            end
            redirect    = (r[9:7] == 3'b000);
            redirect_pc = `FETCH_XLEN'({r[23:16], 2'b00});
            next_cycle();
        end
        stall    = 1'b0;
        redirect = 1'b0;

        phase = "redirect";
        for (int c = 0; c < REDIR_CYCLES; c++) begin
            r           = next_rand();
            redirect    = (r[2:0] < 3'd2);
            redirect_pc = `FETCH_XLEN'({r[23:16], 2'b00});
            next_cycle();
        end
        redirect = 1'b0;

        // loads land ahead of every read still in flight
        phase = "load";
        burst = 0;
        for (int c = 0; c < LOAD_CYCLES; c++) begin
            r = next_rand();
            if (r[1:0] == 2'b00 && burst < 3) begin
                idx         = exp_pc[AW+1:2] + AW'(16) + AW'(r[14:12]);
                load_we     = 1'b1;
                load_addr   = `FETCH_XLEN'(idx);
                load_data   = next_rand();
                shadow[idx] = load_data;
                burst++;
            end else begin
                load_we = 1'b0;
                burst   = 0;
            end
            next_cycle();
        end
        load_we = 1'b0;

        phase = "drain";
        repeat (DRAIN_CYCLES) next_cycle();

        if (checked == 0) begin
            report_failure("no valid instruction ever reached decode");
        end
        sva_errors = dut0.if_id0.sva0.fail_cnt + dut0.mem_arbiter0.sva0.fail_cnt;
        $display("closing: %0d checked, %0d check errors, %0d assertion errors",
                 checked, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction width
`define FETCH_XLEN 32

// first pc fetched after reset
`define FETCH_RESET_PC 32'h0000_0000

// instruction memory size in words
`define FETCH_MEM_DEPTH 256

`endif

/* verilog/fetch_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // one memory request from either the load port or the pc generator
    // addr is a word address, pc >> 2 for fetches
    typedef struct packed {
        logic                   we;    // set for load port writes
        logic [`FETCH_XLEN-1:0] addr;  // word address
        logic [`FETCH_XLEN-1:0] data;  // write data, unused on reads
    } mem_req_t;

    // registered read response from the instruction memory
    typedef struct packed {
        logic                   valid; // low after a write or an idle cycle
        logic [`FETCH_XLEN-1:0] pc;    // byte pc of the request
        logic [`FETCH_XLEN-1:0] inst;
    } mem_rsp_t;

    // IF/ID register contents seen by decode
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] inst;
    } if_id_t;

endpackage

`default_nettype wire

/* verilog/fetch_stall.sv */
`default_nettype none

module fetch_stall (
    input  wire  stall,      // combined hazard and memory stall
    input  wire  fetch_en,
    input  wire  fetch_gnt,  // low when a load took the memory
    output logic freeze,
    output logic advance
);

    logic fetch_ok;

    // external stall freezes every front end stage at once
    assign freeze = stall;

    // a fetch counts only if it was enabled and won the memory
    assign fetch_ok = fetch_en & fetch_gnt;

    // pc moves only when the read it issued is really captured
    // a denied fetch keeps the pc and leaves a bubble behind
    assign advance = fetch_ok & ~stall;

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    fetch_en,
    input  wire                    stall,
    input  wire                    redirect,
    input  wire [`FETCH_XLEN-1:0]  redirect_pc,
    input  wire                    load_we,    // one cycle load strobe
    input  wire [`FETCH_XLEN-1:0]  load_addr,  // word address
    input  wire [`FETCH_XLEN-1:0]  load_data,
    output fetch_pkg::if_id_t      id
);
    import fetch_pkg::*;

    mem_req_t load_req;
    mem_req_t fetch_req;
    logic     fetch_req_valid;
    logic     fetch_gnt;
    mem_req_t mem_req;
    logic     mem_valid;
    mem_rsp_t rsp;
    logic     freeze;
    logic     advance;

    // load fields as a write request
    assign load_req = mem_req_t'{we: 1'b1, addr: load_addr, data: load_data};

    pc_gen pc_gen0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .fetch_en        (fetch_en),
        .advance         (advance),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .fetch_req       (fetch_req),
        .fetch_req_valid (fetch_req_valid)
    );

    mem_arbiter #(
        .req_t (mem_req_t)
    ) mem_arbiter0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_req    (load_req),
        .load_valid  (load_we),
        .fetch_req   (fetch_req),
        .fetch_valid (fetch_req_valid),
        .fetch_gnt   (fetch_gnt),
        .mem_req     (mem_req),
        .mem_valid   (mem_valid)
    );

    inst_mem inst_mem0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .freeze    (freeze),
        .rsp       (rsp)
    );

    fetch_stall fetch_stall0 (
        .stall     (stall),
        .fetch_en  (fetch_en),
        .fetch_gnt (fetch_gnt),
        .freeze    (freeze),
        .advance   (advance)
    );

    // redirect goes straight here as the flush
    if_id if_id0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rsp      (rsp),
        .freeze   (freeze),
        .redirect (redirect),
        .id       (id)
    );

endmodule

`default_nettype wire

/* verilog/if_id.sv */
`default_nettype none

`include "fetch_config.svh"

module if_id (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire fetch_pkg::mem_rsp_t rsp,
    input  wire                  freeze,
    input  wire                  redirect,  // flush request
    output fetch_pkg::if_id_t    id
);
    import fetch_pkg::*;

    logic                   id_valid;
    logic [`FETCH_XLEN-1:0] id_pc;
    logic [`FETCH_XLEN-1:0] id_inst;
    logic                   drop_pending; // response in flight is stale

    // set by redirect, kept through freeze
    // cleared once the next unfrozen cycle consumes the stale response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_pending <= 1'b0;
        end else if (redirect) begin
            drop_pending <= 1'b1;
        end else if (!freeze) begin
            drop_pending <= 1'b0;
        end
    end

    // order is flush, drop, hold, capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else if (redirect) begin
            id_valid <= 1'b0;
        end else if (drop_pending) begin
            id_valid <= 1'b0;       // bubble in place of the stale pc
        end else if (!freeze) begin
            id_valid <= rsp.valid;
        end
    end

    // payload only matters when id_valid is set
    always_ff @(posedge clk) begin
        if (!freeze) begin
            id_pc   <= rsp.pc;
            id_inst <= rsp.inst;
        end
    end

    assign id = if_id_t'{valid: id_valid, pc: id_pc, inst: id_inst};

endmodule

`default_nettype wire

/* verilog/inst_mem.sv */
`default_nettype none

`include "fetch_config.svh"

module inst_mem (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire fetch_pkg::mem_req_t mem_req,
    input  wire                  mem_valid,
    input  wire                  freeze,    // hold the response register
    output fetch_pkg::mem_rsp_t  rsp
);
    import fetch_pkg::*;

    localparam int AW = $clog2(`FETCH_MEM_DEPTH);

    logic [`FETCH_XLEN-1:0] mem [`FETCH_MEM_DEPTH];

    logic                   rd_en;
    logic [AW-1:0]          idx;
    logic                   rsp_valid;
    logic [`FETCH_XLEN-1:0] rsp_pc;
    logic [`FETCH_XLEN-1:0] rsp_inst;

    assign idx   = mem_req.addr[AW-1:0];
    assign rd_en = mem_valid & ~mem_req.we;

    // writes land even while frozen
    always_ff @(posedge clk) begin
        if (mem_valid && mem_req.we) begin
            mem[idx] <= mem_req.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (!freeze) begin
            rsp_valid <= rd_en; // a write leaves a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && rd_en) begin
            rsp_pc   <= {mem_req.addr[`FETCH_XLEN-3:0], 2'b00};
            rsp_inst <= mem[idx];
        end
    end

    assign rsp = mem_rsp_t'{valid: rsp_valid, pc: rsp_pc, inst: rsp_inst};

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`default_nettype none

module mem_arbiter #(
    parameter type req_t = logic
) (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   req_t load_req,
    input  wire   load_valid,   // load strobe, always wins
    input  wire   req_t fetch_req,
    input  wire   fetch_valid,
    output logic  fetch_gnt,
    output req_t  mem_req,
    output logic  mem_valid
);

    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    logic             fetch_denied;
    logic [CNT_W-1:0] deny_cnt;     // consecutive fetch denials

    // fixed priority
    // load first, fetch gets the memory otherwise
    assign fetch_gnt    = fetch_valid & ~load_valid;
    assign fetch_denied = fetch_valid & load_valid;

    assign mem_valid = load_valid | fetch_valid;
    assign mem_req   = load_valid ? load_req : fetch_req;

    // saturating denial count
    // watched by the starvation check
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            deny_cnt <= '0;
        end else if (fetch_denied) begin
            if (deny_cnt != CNT_MAX) begin
                deny_cnt <= deny_cnt + 1'b1;
            end
        end else begin
            deny_cnt <= '0; // granted or idle
        end
    end

endmodule

`default_nettype wire

/* verilog/pc_gen.sv */
`default_nettype none

`include "fetch_config.svh"

module pc_gen (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    fetch_en,        // fetching allowed
    input  wire                    advance,         // granted and not frozen
    input  wire                    redirect,        // branch or jump taken
    input  wire [`FETCH_XLEN-1:0]  redirect_pc,
    output fetch_pkg::mem_req_t    fetch_req,
    output logic                   fetch_req_valid
);
    import fetch_pkg::*;

    logic [`FETCH_XLEN-1:0] pc;
    mem_req_t               rd_req;

    // redirect wins over everything, stall included
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `FETCH_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (advance) begin
            pc <= pc + `FETCH_XLEN'(4);
        end
    end

    // read of the current pc as a word address
    always_comb begin
        rd_req      = '0;
        rd_req.we   = 1'b0;
        rd_req.addr = {2'b00, pc[`FETCH_XLEN-1:2]};
        rd_req.data = '0;
    end

    assign fetch_req       = rd_req;
    assign fetch_req_valid = fetch_en; // one request per enabled cycle

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/mem_arbiter.sv
verilog/inst_mem.sv
verilog/fetch_stall.sv
verilog/if_id.sv
verilog/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_tb.sv
